// ==== design/decode_ctrl/control_rom_table.svh ====
// Control ROM table: the fifteen listed opcodes as case items on the opcode byte
`ifndef CONTROL_ROM_TABLE_SVH
`define CONTROL_ROM_TABLE_SVH

// No ModRM, no immediate
OP_NOP:         entry = '{modrm_pr: 1'b0, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};
OP_HLT:         entry = '{modrm_pr: 1'b0, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};
OP_IRET:        entry = '{modrm_pr: 1'b0, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b1, undef: 1'b0};
OP_RET:         entry = '{modrm_pr: 1'b0, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b1, undef: 1'b0};

// ModRM forms
OP_ADD_RM_R:    entry = '{modrm_pr: 1'b1, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b1, rm_dst: 1'b1, eip_change: 1'b0, undef: 1'b0};
OP_ADD_R_RM:    entry = '{modrm_pr: 1'b1, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b1, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};
OP_MOV_RM_R:    entry = '{modrm_pr: 1'b1, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b0, rm_dst: 1'b1, eip_change: 1'b0, undef: 1'b0};
OP_MOV_R_RM:    entry = '{modrm_pr: 1'b1, imm_len_32: IMM_NONE, imm_len_16: IMM_NONE,
                          rm_src: 1'b1, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};

// Full-size immediates shrink to 2 bytes under 66
OP_ADD_EAX_IMM: entry = '{modrm_pr: 1'b0, imm_len_32: IMM_32, imm_len_16: IMM_16,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};
OP_MOV_EAX_IMM: entry = '{modrm_pr: 1'b0, imm_len_32: IMM_32, imm_len_16: IMM_16,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};
OP_PUSH_IMM:    entry = '{modrm_pr: 1'b0, imm_len_32: IMM_32, imm_len_16: IMM_16,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};
OP_MOV_RM_IMM:  entry = '{modrm_pr: 1'b1, imm_len_32: IMM_32, imm_len_16: IMM_16,
                          rm_src: 1'b0, rm_dst: 1'b1, eip_change: 1'b0, undef: 1'b0};
OP_JMP_REL:     entry = '{modrm_pr: 1'b0, imm_len_32: IMM_32, imm_len_16: IMM_16,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b1, undef: 1'b0};

// Byte immediates
OP_JMP_REL8:    entry = '{modrm_pr: 1'b0, imm_len_32: IMM_8, imm_len_16: IMM_8,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b1, undef: 1'b0};
OP_PUSH_IMM8:   entry = '{modrm_pr: 1'b0, imm_len_32: IMM_8, imm_len_16: IMM_8,
                          rm_src: 1'b0, rm_dst: 1'b0, eip_change: 1'b0, undef: 1'b0};

`endif

// ==== common/decode_pkg.sv ====
// Decode stage shared widths, types, prefix bytes, segment codes and opcodes
package decode_pkg;

  localparam int WINDOW_BYTES = 16;
  localparam int MAX_PREFIXES = 4;

  typedef logic [7:0]                  byte_t;
  typedef logic [31:0]                 addr_t;
  // Byte 0 of the window sits in bits 7:0
  typedef logic [WINDOW_BYTES*8-1:0]   window_t;
  typedef logic [2:0]                  pfx_count_t;
  typedef logic [3:0]                  len_t;
  typedef logic [2:0]                  imm_len_t;
  typedef logic [2:0]                  seg_t;

  // Segment register codes
  localparam seg_t SEG_ES = 3'd0;
  localparam seg_t SEG_CS = 3'd1;
  localparam seg_t SEG_SS = 3'd2;
  localparam seg_t SEG_DS = 3'd3;
  localparam seg_t SEG_FS = 3'd4;
  localparam seg_t SEG_GS = 3'd5;

  // Prefix bytes
  localparam byte_t PFX_REPNE  = 8'hF2;
  localparam byte_t PFX_CS     = 8'h2E;
  localparam byte_t PFX_SS     = 8'h36;
  localparam byte_t PFX_DS     = 8'h3E;
  localparam byte_t PFX_ES     = 8'h26;
  localparam byte_t PFX_FS     = 8'h64;
  localparam byte_t PFX_GS     = 8'h65;
  localparam byte_t PFX_OPSIZE = 8'h66;

  // One-byte opcodes known to the control table
  localparam byte_t OP_NOP         = 8'h90;
  localparam byte_t OP_HLT         = 8'hF4;
  localparam byte_t OP_IRET        = 8'hCF;
  localparam byte_t OP_RET         = 8'hC3;
  localparam byte_t OP_ADD_RM_R    = 8'h01;
  localparam byte_t OP_ADD_R_RM    = 8'h03;
  localparam byte_t OP_MOV_RM_R    = 8'h89;
  localparam byte_t OP_MOV_R_RM    = 8'h8B;
  localparam byte_t OP_ADD_EAX_IMM = 8'h05;
  localparam byte_t OP_MOV_EAX_IMM = 8'hB8;
  localparam byte_t OP_PUSH_IMM    = 8'h68;
  localparam byte_t OP_MOV_RM_IMM  = 8'hC7;
  localparam byte_t OP_JMP_REL     = 8'hE9;
  localparam byte_t OP_JMP_REL8    = 8'hEB;
  localparam byte_t OP_PUSH_IMM8   = 8'h6A;

  // Immediate sizes in bytes
  localparam imm_len_t IMM_NONE = 3'd0;
  localparam imm_len_t IMM_8    = 3'd1;
  localparam imm_len_t IMM_16   = 3'd2;
  localparam imm_len_t IMM_32   = 3'd4;

  // One row of the opcode control ROM
  typedef struct packed {
    logic     modrm_pr;
    imm_len_t imm_len_32;
    imm_len_t imm_len_16;
    logic     rm_src;
    logic     rm_dst;
    logic     eip_change;
    logic     undef;
  } ctrl_entry_t;

endpackage

// ==== design/prefix_scan.sv ====
// Prefix scan stage: registers the fetch window and decodes the leading prefixes
`timescale 1ns/1ps

module prefix_scan (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  decode_pkg::window_t    ic_bytes,
  input  decode_pkg::addr_t      eip,
  output logic                   s1_valid,
  output decode_pkg::window_t    s1_bytes,
  output decode_pkg::addr_t      s1_eip,
  output decode_pkg::pfx_count_t pfx_count,
  output logic                   repne,
  output logic                   size_over,
  output logic                   seg_over,
  output decode_pkg::seg_t       seg
);
  import decode_pkg::*;

  byte_t                   lead [MAX_PREFIXES];
  logic [MAX_PREFIXES-1:0] is_repne;
  logic [MAX_PREFIXES-1:0] is_opsize;
  logic [MAX_PREFIXES-1:0] is_es;
  logic [MAX_PREFIXES-1:0] is_cs;
  logic [MAX_PREFIXES-1:0] is_ss;
  logic [MAX_PREFIXES-1:0] is_ds;
  logic [MAX_PREFIXES-1:0] is_fs;
  logic [MAX_PREFIXES-1:0] is_gs;
  logic [MAX_PREFIXES-1:0] is_pfx;
  logic [MAX_PREFIXES-1:0] therm;
  logic [MAX_PREFIXES-1:0] any_seg;
  pfx_count_t              cnt;
  seg_t                    seg_code;

  for (genvar g = 0; g < MAX_PREFIXES; g++) begin : g_lead
    assign lead[g] = ic_bytes[8*g +: 8];
  end

  always_comb begin
    for (int i = 0; i < MAX_PREFIXES; i++) begin
      is_repne[i]  = (lead[i] == PFX_REPNE);
      is_opsize[i] = (lead[i] == PFX_OPSIZE);
      is_es[i]     = (lead[i] == PFX_ES);
      is_cs[i]     = (lead[i] == PFX_CS);
      is_ss[i]     = (lead[i] == PFX_SS);
      is_ds[i]     = (lead[i] == PFX_DS);
      is_fs[i]     = (lead[i] == PFX_FS);
      is_gs[i]     = (lead[i] == PFX_GS);
    end
  end

  assign any_seg = is_es | is_cs | is_ss | is_ds | is_fs | is_gs;
  assign is_pfx  = any_seg | is_repne | is_opsize;

  // Thermometer: a byte counts only if every byte before it is a prefix too
  always_comb begin
    therm[0] = is_pfx[0];
    for (int i = 1; i < MAX_PREFIXES; i++) begin
      therm[i] = therm[i-1] & is_pfx[i];
    end
    cnt = '0;
    for (int i = 0; i < MAX_PREFIXES; i++) begin
      cnt = cnt + pfx_count_t'(therm[i]);
    end
  end

  // Highest segment code wins
  always_comb begin
    if (|(is_gs & therm)) seg_code = SEG_GS;
    else if (|(is_fs & therm)) seg_code = SEG_FS;
    else if (|(is_ds & therm)) seg_code = SEG_DS;
    else if (|(is_ss & therm)) seg_code = SEG_SS;
    else if (|(is_cs & therm)) seg_code = SEG_CS;
    else seg_code = SEG_ES;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_bytes  <= ic_bytes;
      s1_eip    <= eip;
      pfx_count <= cnt;
      repne     <= |(is_repne & therm);
      size_over <= |(is_opsize & therm);
      seg_over  <= |(any_seg & therm);
      seg       <= seg_code;
    end
  end

  pfx_count_max: assert property (@(posedge clk) disable iff (rst)
    s1_valid |-> pfx_count <= MAX_PREFIXES);

endmodule

// ==== design/decode_ctrl/control_rom.sv ====
// Opcode control ROM: looks up control bits and picks the immediate size by operand size
`timescale 1ns/1ps

module control_rom (
  input  decode_pkg::byte_t    opcode,
  input  logic                 size_over,
  output logic                 modrm_pr,
  output logic                 rm_src,
  output logic                 rm_dst,
  output logic                 eip_change,
  output logic                 undef,
  output decode_pkg::imm_len_t imm_len
);
  import decode_pkg::*;

  ctrl_entry_t entry;

  always_comb begin
    case (opcode)
      `include "control_rom_table.svh"
      // Anything not in the table, 0F included
      default: entry = '{undef: 1'b1, default: '0};
    endcase
  end

  assign modrm_pr   = entry.modrm_pr;
  assign rm_src     = entry.rm_src;
  assign rm_dst     = entry.rm_dst;
  assign eip_change = entry.eip_change;
  assign undef      = entry.undef;

  // 66 prefix selects the 16-bit column
  assign imm_len = size_over ? entry.imm_len_16 : entry.imm_len_32;

  undef_exclusive: assert final (!undef ||
    !(modrm_pr || rm_src || rm_dst || eip_change || imm_len != IMM_NONE));

endmodule

// ==== design/field_extract.sv ====
// Field extraction: locates opcode, ModRM, displacement and immediate and sums the length
`timescale 1ns/1ps

module field_extract (
  input  decode_pkg::window_t    s1_bytes,
  input  decode_pkg::pfx_count_t pfx_count,
  input  logic                   modrm_pr,
  input  decode_pkg::imm_len_t   imm_len,
  output decode_pkg::byte_t      opcode,
  output logic                   mod_reg,
  output decode_pkg::addr_t      disp32,
  output decode_pkg::addr_t      imm32,
  output decode_pkg::len_t       len
);
  import decode_pkg::*;

  byte_t      modrm;
  logic [1:0] mod;
  logic [2:0] rm;
  logic       sib_pr;
  logic [2:0] modrm_len;
  logic [2:0] modrm_bytes;
  logic [3:0] modrm_pos;
  logic [3:0] disp_pos;
  logic [3:0] imm_pos;
  logic [4:0] len_sum;

  // Opcode follows the prefixes, ModRM follows the opcode
  assign modrm_pos = 4'(pfx_count) + 4'd1;
  assign opcode    = s1_bytes[{pfx_count, 3'b000} +: 8];
  assign modrm     = s1_bytes[{modrm_pos, 3'b000} +: 8];

  assign mod     = modrm[7:6];
  assign rm      = modrm[2:0];
  assign mod_reg = (mod == 2'b11);
  assign sib_pr  = (rm == 3'b100) && !mod_reg;

  // ModRM bytes including SIB and displacement
  always_comb begin
    case (mod)
      2'b00: begin
        if (rm == 3'b101) begin
          modrm_len = 3'd5;
        end else if (rm == 3'b100) begin
          modrm_len = 3'd2;
        end else begin
          modrm_len = 3'd1;
        end
      end
      2'b01:   modrm_len = sib_pr ? 3'd3 : 3'd2;
      2'b10:   modrm_len = sib_pr ? 3'd6 : 3'd5;
      default: modrm_len = 3'd1;
    endcase
  end

  assign modrm_bytes = modrm_pr ? modrm_len : 3'd0;

  // Raw 32-bit windows, the consumer trims by size
  assign disp_pos = modrm_pos + 4'd1 + 4'(sib_pr);
  assign imm_pos  = modrm_pos + 4'(modrm_bytes);
  assign disp32   = s1_bytes[{disp_pos, 3'b000} +: 32];
  assign imm32    = s1_bytes[{imm_pos, 3'b000} +: 32];

  assign len_sum = 5'(pfx_count) + 5'd1 + 5'(modrm_bytes) + 5'(imm_len);
  assign len     = len_t'(len_sum);

  len_fits: assert final (len_sum <= 5'(WINDOW_BYTES - 1));

endmodule

// ==== design/decode_result.sv ====
// Decode result stage: next EIP adder, memory and HLT/IRET flags, output register
`timescale 1ns/1ps

module decode_result (
  input  logic                clk,
  input  logic                rst,
  input  logic                s1_valid,
  input  decode_pkg::addr_t   s1_eip,
  input  decode_pkg::len_t    len,
  input  decode_pkg::byte_t   opcode,
  input  logic                mod_reg,
  input  logic                rm_src,
  input  logic                rm_dst,
  input  logic                eip_change,
  input  logic                undef,
  input  logic                repne,
  input  logic                size_over,
  input  logic                seg_over,
  input  decode_pkg::seg_t    seg,
  input  decode_pkg::addr_t   disp32,
  input  decode_pkg::addr_t   imm32,
  output logic                out_valid,
  output decode_pkg::addr_t   de_eip_next,
  output decode_pkg::len_t    de_len,
  output logic                de_hlt,
  output logic                de_iret,
  output logic                de_mem_read,
  output logic                de_ld_mem,
  output logic                de_eip_change,
  output logic                de_undef,
  output logic                de_repne,
  output logic                de_size_over,
  output logic                de_seg_over,
  output decode_pkg::seg_t    de_seg,
  output decode_pkg::addr_t   de_disp32,
  output decode_pkg::addr_t   de_imm32
);
  import decode_pkg::*;

  addr_t eip_next;

  // Wraps at 2^32
  assign eip_next = s1_eip + addr_t'(len);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      de_eip_next   <= eip_next;
      de_len        <= len;
      de_hlt        <= (opcode == OP_HLT);
      de_iret       <= (opcode == OP_IRET);
      // Memory only when r/m is not a register
      de_mem_read   <= rm_src && !mod_reg;
      de_ld_mem     <= rm_dst && !mod_reg;
      de_eip_change <= eip_change;
      de_undef      <= undef;
      de_repne      <= repne;
      de_size_over  <= size_over;
      de_seg_over   <= seg_over;
      de_seg        <= seg;
      de_disp32     <= disp32;
      de_imm32      <= imm32;
    end
  end

  hlt_iret_exclusive: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !(de_hlt && de_iret));

endmodule

// ==== design/decode_top.sv ====
// Decode stage top: prefix scan, control lookup, field extraction and result register
`timescale 1ns/1ps

module decode_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  decode_pkg::window_t ic_bytes,
  input  decode_pkg::addr_t   eip,
  output logic                out_valid,
  output decode_pkg::addr_t   de_eip_next,
  output decode_pkg::len_t    de_len,
  output logic                de_repne,
  output logic                de_size_over,
  output logic                de_seg_over,
  output decode_pkg::seg_t    de_seg,
  output decode_pkg::addr_t   de_disp32,
  output decode_pkg::addr_t   de_imm32,
  output logic                de_hlt,
  output logic                de_iret,
  output logic                de_eip_change,
  output logic                de_mem_read,
  output logic                de_ld_mem,
  output logic                de_undef
);
  import decode_pkg::*;

  logic       s1_valid;
  window_t    s1_bytes;
  addr_t      s1_eip;
  pfx_count_t pfx_count;
  logic       repne;
  logic       size_over;
  logic       seg_over;
  seg_t       seg;
  byte_t      opcode;
  logic       modrm_pr;
  logic       rm_src;
  logic       rm_dst;
  logic       eip_change;
  logic       undef;
  imm_len_t   imm_len;
  logic       mod_reg;
  addr_t      disp32;
  addr_t      imm32;
  len_t       len;

  prefix_scan u_prefix_scan (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .ic_bytes  (ic_bytes),
    .eip       (eip),
    .s1_valid  (s1_valid),
    .s1_bytes  (s1_bytes),
    .s1_eip    (s1_eip),
    .pfx_count (pfx_count),
    .repne     (repne),
    .size_over (size_over),
    .seg_over  (seg_over),
    .seg       (seg)
  );

  control_rom u_control_rom (
    .opcode     (opcode),
    .size_over  (size_over),
    .modrm_pr   (modrm_pr),
    .rm_src     (rm_src),
    .rm_dst     (rm_dst),
    .eip_change (eip_change),
    .undef      (undef),
    .imm_len    (imm_len)
  );

  field_extract u_field_extract (
    .s1_bytes  (s1_bytes),
    .pfx_count (pfx_count),
    .modrm_pr  (modrm_pr),
    .imm_len   (imm_len),
    .opcode    (opcode),
    .mod_reg   (mod_reg),
    .disp32    (disp32),
    .imm32     (imm32),
    .len       (len)
  );

  decode_result u_decode_result (
    .clk           (clk),
    .rst           (rst),
    .s1_valid      (s1_valid),
    .s1_eip        (s1_eip),
    .len           (len),
    .opcode        (opcode),
    .mod_reg       (mod_reg),
    .rm_src        (rm_src),
    .rm_dst        (rm_dst),
    .eip_change    (eip_change),
    .undef         (undef),
    .repne         (repne),
    .size_over     (size_over),
    .seg_over      (seg_over),
    .seg           (seg),
    .disp32        (disp32),
    .imm32         (imm32),
    .out_valid     (out_valid),
    .de_eip_next   (de_eip_next),
    .de_len        (de_len),
    .de_hlt        (de_hlt),
    .de_iret       (de_iret),
    .de_mem_read   (de_mem_read),
    .de_ld_mem     (de_ld_mem),
    .de_eip_change (de_eip_change),
    .de_undef      (de_undef),
    .de_repne      (de_repne),
    .de_size_over  (de_size_over),
    .de_seg_over   (de_seg_over),
    .de_seg        (de_seg),
    .de_disp32     (de_disp32),
    .de_imm32      (de_imm32)
  );

endmodule

// ==== bench/decode_tb_model.svh ====
// Decode testbench model with the LFSR, the window builder and the expected-result functions
`ifndef DECODE_TB_MODEL_SVH
`define DECODE_TB_MODEL_SVH

typedef struct packed {
  logic     listed;
  logic     modrm_pr;
  logic     rm_src;
  logic     rm_dst;
  logic     eip_change;
  imm_len_t imm_32;
  imm_len_t imm_16;
} op_info_t;

typedef struct packed {
  addr_t eip_next;
  len_t  len;
  logic  repne;
  logic  size_over;
  logic  seg_over;
  seg_t  seg;
  addr_t disp32;
  addr_t imm32;
  logic  has_modrm;
  logic  hlt;
  logic  iret;
  logic  eip_change;
  logic  mem_read;
  logic  ld_mem;
  logic  undef;
} expect_t;

logic [15:0] lfsr_state;

// Taps 16, 14, 13, 11
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_bit()};
  end
  return r;
endfunction

function automatic byte_t prefix_at(input logic [2:0] idx);
  case (idx)
    3'd0:    return PFX_REPNE;
    3'd1:    return PFX_CS;
    3'd2:    return PFX_SS;
    3'd3:    return PFX_DS;
    3'd4:    return PFX_ES;
    3'd5:    return PFX_FS;
    3'd6:    return PFX_GS;
    default: return PFX_OPSIZE;
  endcase
endfunction

function automatic logic is_prefix(input byte_t b);
  return b inside {PFX_REPNE, PFX_CS, PFX_SS, PFX_DS, PFX_ES, PFX_FS, PFX_GS, PFX_OPSIZE};
endfunction

// Segment code of a segment prefix or -1 for any other byte
function automatic int seg_code(input byte_t b);
  case (b)
    PFX_ES:  return int'(SEG_ES);
    PFX_CS:  return int'(SEG_CS);
    PFX_SS:  return int'(SEG_SS);
    PFX_DS:  return int'(SEG_DS);
    PFX_FS:  return int'(SEG_FS);
    PFX_GS:  return int'(SEG_GS);
    default: return -1;
  endcase
endfunction

// Flag bits listed modrm src dst eip_change, then the 32-bit and 16-bit immediate sizes
function automatic op_info_t op_info(input byte_t op);
  case (op)
    8'h90:   return {5'b10000, IMM_NONE, IMM_NONE};
    8'hF4:   return {5'b10000, IMM_NONE, IMM_NONE};
    8'hCF:   return {5'b10001, IMM_NONE, IMM_NONE};
    8'hC3:   return {5'b10001, IMM_NONE, IMM_NONE};
    8'h01:   return {5'b11110, IMM_NONE, IMM_NONE};
    8'h03:   return {5'b11100, IMM_NONE, IMM_NONE};
    8'h89:   return {5'b11010, IMM_NONE, IMM_NONE};
    8'h8B:   return {5'b11100, IMM_NONE, IMM_NONE};
    8'h05:   return {5'b10000, IMM_32, IMM_16};
    8'hB8:   return {5'b10000, IMM_32, IMM_16};
    8'h68:   return {5'b10000, IMM_32, IMM_16};
    8'hC7:   return {5'b11010, IMM_32, IMM_16};
    8'hE9:   return {5'b10001, IMM_32, IMM_16};
    8'hEB:   return {5'b10001, IMM_8, IMM_8};
    8'h6A:   return {5'b10000, IMM_8, IMM_8};
    default: return '0;
  endcase
endfunction

function automatic byte_t table_opcode(input logic [3:0] idx);
  byte_t ops [15];
  ops = '{8'h90, 8'hF4, 8'hCF, 8'hC3, 8'h01, 8'h03, 8'h89, 8'h8B,
          8'h05, 8'hB8, 8'h68, 8'hC7, 8'hE9, 8'hEB, 8'h6A};
  return ops[idx];
endfunction

// Index 15 picks an unlisted byte
function automatic byte_t pick_opcode(input logic [3:0] idx);
  byte_t    op;
  op_info_t info;
  if (idx != 4'd15) begin
    return table_opcode(idx);
  end
  op   = byte_t'(rand_bits(8));
  info = op_info(op);
  // A prefix byte here would extend the scan
  if (info.listed || is_prefix(op)) begin
    op = 8'h0F;
  end
  return op;
endfunction

function automatic int modrm_length(input byte_t modrm);
  case (modrm[7:6])
    2'b00: begin
      if (modrm[2:0] == 3'b101) return 5;
      else if (modrm[2:0] == 3'b100) return 2;
      else return 1;
    end
    2'b01:   return (modrm[2:0] == 3'b100) ? 3 : 2;
    2'b10:   return (modrm[2:0] == 3'b100) ? 6 : 5;
    default: return 1;
  endcase
endfunction

function automatic byte_t byte_at(input window_t w, input int i);
  return w[8*i +: 8];
endfunction

function automatic expect_t expect_of(input window_t w, input addr_t e);
  expect_t  x;
  op_info_t info;
  byte_t    b;
  byte_t    op;
  byte_t    modrm;
  logic     stop;
  int       n;
  int       best;
  int       mlen;
  int       ilen;
  int       disp_pos;
  x    = '0;
  n    = 0;
  best = -1;
  stop = 1'b0;
  for (int i = 0; i < MAX_PREFIXES; i++) begin
    b = byte_at(w, i);
    if (!stop && is_prefix(b)) begin
      n++;
      if (b == PFX_REPNE) x.repne = 1'b1;
      if (b == PFX_OPSIZE) x.size_over = 1'b1;
      if (seg_code(b) > best) best = seg_code(b);
    end else begin
      stop = 1'b1;
    end
  end
  x.seg_over = (best >= 0);
  x.seg      = x.seg_over ? seg_t'(best) : SEG_ES;

  op    = byte_at(w, n);
  modrm = byte_at(w, n + 1);
  info  = op_info(op);
  mlen  = info.modrm_pr ? modrm_length(modrm) : 0;
  ilen  = x.size_over ? int'(info.imm_16) : int'(info.imm_32);

  x.len      = len_t'(n + 1 + mlen + ilen);
  x.eip_next = e + addr_t'(n + 1 + mlen + ilen);
  // SIB sits between ModRM and displacement
  disp_pos    = n + 2 + ((modrm[2:0] == 3'b100 && modrm[7:6] != 2'b11) ? 1 : 0);
  x.disp32    = w[8*disp_pos +: 32];
  x.imm32     = w[8*(n + 1 + mlen) +: 32];
  x.has_modrm = info.modrm_pr;

  x.hlt        = (op == OP_HLT);
  x.iret       = (op == OP_IRET);
  x.undef      = !info.listed;
  x.eip_change = info.eip_change;
  x.mem_read   = info.rm_src && (modrm[7:6] != 2'b11);
  x.ld_mem     = info.rm_dst && (modrm[7:6] != 2'b11);
  return x;
endfunction

// Random fill with prefixes, opcode and ModRM written over the front
function automatic window_t build_window(input int n_pfx, input byte_t op, input byte_t modrm);
  window_t w;
  for (int i = 0; i < WINDOW_BYTES; i++) begin
    w[8*i +: 8] = byte_t'(rand_bits(8));
  end
  for (int i = 0; i < n_pfx; i++) begin
    w[8*i +: 8] = prefix_at(3'(rand_bits(3)));
  end
  w[8*n_pfx +: 8]       = op;
  w[8*(n_pfx + 1) +: 8] = modrm;
  return w;
endfunction

`endif

// ==== bench/decode_tb.sv ====
// Decode stage testbench checking random and directed instructions against a reference model
`timescale 1ns/1ps

module decode_tb;
  import decode_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int N_RANDOM     = 240;
  localparam int N_SWEEP      = 64;
  localparam int N_SEG        = 6;
  localparam int N_WRAP       = 8;
  localparam int N_TESTS      = 5;
  // One cycle per vector plus a few per test to drain
  localparam int TIMEOUT_CYCLES =
    RESET_CYCLES + N_RANDOM + N_SWEEP + N_SEG + N_WRAP + 6 * N_TESTS + 20;

  // Leading four bytes with byte 0 in the low bits
  localparam logic [31:0] SEG_LEADS [N_SEG] = '{
    32'h3E2E6526, 32'h90643E36, 32'h0566262E,
    32'hF2669026, 32'h683666F2, 32'h2EC76564
  };

  logic    clk;
  logic    rst;
  logic    in_valid;
  window_t ic_bytes;
  addr_t   eip;
  logic    out_valid;
  addr_t   de_eip_next;
  len_t    de_len;
  logic    de_repne;
  logic    de_size_over;
  logic    de_seg_over;
  seg_t    de_seg;
  addr_t   de_disp32;
  addr_t   de_imm32;
  logic    de_hlt;
  logic    de_iret;
  logic    de_eip_change;
  logic    de_mem_read;
  logic    de_ld_mem;
  logic    de_undef;

  `include "decode_tb_model.svh"

  expect_t exp_q [$];
  expect_t cur;
  int      errors;
  int      n_vectors;
  int      n_checked;
  int      cycles;

  decode_top uut (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .ic_bytes      (ic_bytes),
    .eip           (eip),
    .out_valid     (out_valid),
    .de_eip_next   (de_eip_next),
    .de_len        (de_len),
    .de_repne      (de_repne),
    .de_size_over  (de_size_over),
    .de_seg_over   (de_seg_over),
    .de_seg        (de_seg),
    .de_disp32     (de_disp32),
    .de_imm32      (de_imm32),
    .de_hlt        (de_hlt),
    .de_iret       (de_iret),
    .de_eip_change (de_eip_change),
    .de_mem_read   (de_mem_read),
    .de_ld_mem     (de_ld_mem),
    .de_undef      (de_undef)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, want);
    errors++;
  endtask

  task automatic issue(input window_t w, input addr_t e);
    @(posedge clk);
    in_valid <= 1'b1;
    ic_bytes <= w;
    eip      <= e;
    exp_q.push_back(expect_of(w, e));
    n_vectors++;
  endtask

  task automatic finish_test(input string name, input int err0, input int vec0);
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    @(negedge clk);
    $display("test %-8s %0d vectors, %0d errors", name, n_vectors - vec0, errors - err0);
  endtask

  // Front of the queue becomes current while its result is on the outputs
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: out_valid high with no instruction outstanding", $time);
        errors++;
      end else begin
        cur = exp_q.pop_front();
        n_checked++;
      end
    end
  end

  property valid_match(ok);
    @(posedge clk) disable iff (rst) out_valid |-> ok;
  endproperty

  reset_low: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      $display("error at %0t: out_valid high during reset", $time);
      errors++;
    end
  latency_two: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 2))
    else begin
      $display("error at %0t: out_valid not exactly two cycles after in_valid", $time);
      errors++;
    end

  chk_eip_next: assert property (valid_match(de_eip_next == cur.eip_next))
    else report_mismatch("de_eip_next", $sampled(de_eip_next), cur.eip_next);
  chk_len: assert property (valid_match(de_len == cur.len))
    else report_mismatch("de_len", $sampled(de_len), cur.len);
  chk_repne: assert property (valid_match(de_repne == cur.repne))
    else report_mismatch("de_repne", $sampled(de_repne), cur.repne);
  chk_size_over: assert property (valid_match(de_size_over == cur.size_over))
    else report_mismatch("de_size_over", $sampled(de_size_over), cur.size_over);
  chk_seg_over: assert property (valid_match(de_seg_over == cur.seg_over))
    else report_mismatch("de_seg_over", $sampled(de_seg_over), cur.seg_over);
  chk_seg: assert property (valid_match(!cur.seg_over || de_seg == cur.seg))
    else report_mismatch("de_seg", $sampled(de_seg), cur.seg);
  chk_disp32: assert property (valid_match(!cur.has_modrm || de_disp32 == cur.disp32))
    else report_mismatch("de_disp32", $sampled(de_disp32), cur.disp32);
  chk_imm32: assert property (valid_match(de_imm32 == cur.imm32))
    else report_mismatch("de_imm32", $sampled(de_imm32), cur.imm32);
  chk_hlt: assert property (valid_match(de_hlt == cur.hlt))
    else report_mismatch("de_hlt", $sampled(de_hlt), cur.hlt);
  chk_iret: assert property (valid_match(de_iret == cur.iret))
    else report_mismatch("de_iret", $sampled(de_iret), cur.iret);
  chk_eip_change: assert property (valid_match(de_eip_change == cur.eip_change))
    else report_mismatch("de_eip_change", $sampled(de_eip_change), cur.eip_change);
  chk_mem_read: assert property (valid_match(de_mem_read == cur.mem_read))
    else report_mismatch("de_mem_read", $sampled(de_mem_read), cur.mem_read);
  chk_ld_mem: assert property (valid_match(de_ld_mem == cur.ld_mem))
    else report_mismatch("de_ld_mem", $sampled(de_ld_mem), cur.ld_mem);
  chk_undef: assert property (valid_match(de_undef == cur.undef))
    else report_mismatch("de_undef", $sampled(de_undef), cur.undef);

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int      err0;
    int      vec0;
    int      n;
    byte_t   op;
    byte_t   modrm;
    window_t w;
    addr_t   e;
    lfsr_state = 16'd8687;
    errors     = 0;
    n_vectors  = 0;
    n_checked  = 0;
    cur        = '0;
    rst        = 1'b1;
    in_valid   = 1'b1;
    ic_bytes   = '0;
    eip        = '0;

    // Strobes early in reset must not reach the outputs
    repeat (2) @(posedge clk);
    in_valid <= 1'b0;
    repeat (RESET_CYCLES - 2) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(negedge clk);
    $display("test reset    out_valid low through reset, %0d errors", errors);

    // Random prefixes, opcodes and ModRM issued back to back
    err0 = errors;
    vec0 = n_vectors;
    for (int i = 0; i < N_RANDOM; i++) begin
      n     = rand_bits(3) % 5;
      op    = pick_opcode(4'(rand_bits(4)));
      modrm = byte_t'(rand_bits(8));
      w     = build_window(n, op, modrm);
      e     = rand_bits(32);
      issue(w, e);
    end
    finish_test("random", err0, vec0);

    // Every opcode slot against every mod class
    err0 = errors;
    vec0 = n_vectors;
    for (int idx = 0; idx < 16; idx++) begin
      for (int m = 0; m < 4; m++) begin
        n     = rand_bits(3) % 5;
        op    = pick_opcode(4'(idx));
        // r/m follows the slot so the ModRM opcodes meet the SIB and disp32 forms
        modrm = {2'(m), 3'(rand_bits(3)), 3'(idx)};
        w     = build_window(n, op, modrm);
        e     = rand_bits(32);
        issue(w, e);
      end
    end
    finish_test("sweep", err0, vec0);

    // Segment priority and scan stop
    err0 = errors;
    vec0 = n_vectors;
    for (int i = 0; i < N_SEG; i++) begin
      w        = build_window(0, OP_NOP, byte_t'(rand_bits(8)));
      w[31:0]  = SEG_LEADS[i];
      e        = rand_bits(32);
      issue(w, e);
    end
    finish_test("segment", err0, vec0);

    // EIP close to the top so the adder wraps
    err0 = errors;
    vec0 = n_vectors;
    for (int i = 0; i < N_WRAP; i++) begin
      n     = rand_bits(3) % 5;
      op    = pick_opcode(4'(rand_bits(4)));
      modrm = byte_t'(rand_bits(8));
      w     = build_window(n, op, modrm);
      e     = 32'hFFFF_FFF8 | rand_bits(3);
      issue(w, e);
    end
    finish_test("wrap", err0, vec0);

    if (n_checked != n_vectors) begin
      $display("error: %0d instructions issued but %0d returned", n_vectors, n_checked);
      errors++;
    end
    $display("summary: %0d tests, %0d vectors, %0d checked, %0d errors",
             N_TESTS, n_vectors, n_checked, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== x86_decode.f ====
+incdir+design/decode_ctrl
+incdir+bench
common/decode_pkg.sv
design/prefix_scan.sv
design/decode_ctrl/control_rom.sv
design/field_extract.sv
design/decode_result.sv
design/decode_top.sv
bench/decode_tb.sv

// ==== Bender.yml ====
package:
  name: x86_decode

sources:
  - include_dirs:
      - design/decode_ctrl
    files:
      - common/decode_pkg.sv
      - design/prefix_scan.sv
      - design/decode_ctrl/control_rom.sv
      - design/field_extract.sv
      - design/decode_result.sv
      - design/decode_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/decode_tb.sv
